// File: Makefile
TOP = tb_mgmt_core

all: run

obj_dir/V$(TOP): mgmt_core.f include/mgmt_config.svh $(wildcard logic/*.sv) testbench/$(TOP).sv
	verilator --binary --timing --top-module $(TOP) -f mgmt_core.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: include/mgmt_config.svh
/*
 * Management core constants: pad count, housekeeping register map,
 * SPI command bytes and register reset values
 */
`ifndef MGMT_CONFIG_SVH
`define MGMT_CONFIG_SVH

// Number of user I/O pins
`define MPRJ_IO_PADS 16

// Housekeeping register address width
`define HK_ADDR_W 4

// Register map, mask revision is most significant byte first
`define HK_REG_MASK0 4'd0
`define HK_REG_MASK1 4'd1
`define HK_REG_MASK2 4'd2
`define HK_REG_MASK3 4'd3
`define HK_REG_CLKDIV 4'd4
`define HK_REG_CTRL 4'd5
`define HK_REG_OUT_LO 4'd6
`define HK_REG_OUT_HI 4'd7
`define HK_REG_OEB_LO 4'd8
`define HK_REG_OEB_HI 4'd9
`define HK_REG_IN_LO 4'd10
`define HK_REG_IN_HI 4'd11

// SPI command bytes
`define HK_CMD_WRITE 8'h80
`define HK_CMD_READ 8'h40

// All user pins start with their outputs disabled
`define HK_OEB_RESET {`MPRJ_IO_PADS{1'b1}}

`endif

// File: logic/hk_regs.sv
/*
 * Housekeeping register file: SPI command/address/data FSM,
 * auto-incrementing address, config registers, IRQ pulse and read mux
 */
`timescale 1ns/1ps
`include "mgmt_config.svh"

module hk_regs (
	input logic clock,
	input logic rst_i,
	input mgmt_pkg::spi_byte_t rx_i,
	input logic rx_valid_i,
	input logic active_i,
	output logic [7:0] tx_byte_o,
	output logic tx_load_o,
	output logic sdo_enb_o,
	input logic [31:0] mask_rev_i,
	input logic [`MPRJ_IO_PADS-1:0] io_in_i,
	output mgmt_pkg::hk_cfg_t cfg_o,
	output logic irq_o
);

	typedef enum logic [1:0] {
		ST_CMD,
		ST_ADDR,
		ST_DATA,
		ST_IGNORE
	} state_e;

	state_e state_q;
	// Current transaction is a read
	logic is_rd_q;
	logic [`HK_ADDR_W-1:0] addr_q;
	logic [`HK_ADDR_W-1:0] next_addr;
	mgmt_pkg::hk_cfg_t cfg_q;
	logic [`MPRJ_IO_PADS-1:0] in_s1_q;
	logic [`MPRJ_IO_PADS-1:0] in_s2_q;

	// Input pins into the clock domain
	always_ff @(posedge clock) begin
		in_s1_q <= io_in_i;
		in_s2_q <= in_s1_q;
	end

	always_ff @(posedge clock) begin
		if (rst_i) begin
			state_q <= ST_CMD;
			is_rd_q <= 1'b0;
			addr_q <= '0;
			irq_o <= 1'b0;
			cfg_q.clk_div <= 3'd0;
			cfg_q.ext_reset <= 1'b0;
			cfg_q.sdo_override <= 1'b0;
			cfg_q.io_out <= '0;
			cfg_q.io_oeb <= `HK_OEB_RESET;
		end else begin
			irq_o <= 1'b0;
			if (!active_i) begin
				// CSB high ends any transaction
				state_q <= ST_CMD;
			end else if (rx_valid_i) begin
				if (rx_i.first) begin
					// Command byte
					if (rx_i.data == `HK_CMD_WRITE) begin
						state_q <= ST_ADDR;
						is_rd_q <= 1'b0;
					end else if (rx_i.data == `HK_CMD_READ) begin
						state_q <= ST_ADDR;
						is_rd_q <= 1'b1;
					end else begin
						state_q <= ST_IGNORE;
					end
				end else begin
					case (state_q)
						ST_ADDR: begin
							addr_q <= rx_i.data[`HK_ADDR_W-1:0];
							state_q <= ST_DATA;
						end
						ST_DATA: begin
							// Wraps at 16
							addr_q <= addr_q + 1'b1;
							if (!is_rd_q) begin
								// Read-only and unused addresses fall through
								case (addr_q)
									`HK_REG_CLKDIV: cfg_q.clk_div <= rx_i.data[2:0];
									`HK_REG_CTRL: begin
										cfg_q.ext_reset <= rx_i.data[0];
										cfg_q.sdo_override <= rx_i.data[1];
										// Self-clearing interrupt request
										irq_o <= rx_i.data[2];
									end
									`HK_REG_OUT_LO: cfg_q.io_out[7:0] <= rx_i.data;
									`HK_REG_OUT_HI: cfg_q.io_out[`MPRJ_IO_PADS-1:8] <= rx_i.data;
									`HK_REG_OEB_LO: cfg_q.io_oeb[7:0] <= rx_i.data;
									`HK_REG_OEB_HI: cfg_q.io_oeb[`MPRJ_IO_PADS-1:8] <= rx_i.data;
									default: ;
								endcase
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

	assign cfg_o = cfg_q;

	// Address of the byte to send next: start address, then the following one
	assign next_addr = (state_q == ST_ADDR) ? rx_i.data[`HK_ADDR_W-1:0] : addr_q + 1'b1;

	// Read mux, unused addresses give 0
	always_comb begin
		case (next_addr)
			`HK_REG_MASK0: tx_byte_o = mask_rev_i[31:24];
			`HK_REG_MASK1: tx_byte_o = mask_rev_i[23:16];
			`HK_REG_MASK2: tx_byte_o = mask_rev_i[15:8];
			`HK_REG_MASK3: tx_byte_o = mask_rev_i[7:0];
			`HK_REG_CLKDIV: tx_byte_o = {5'd0, cfg_q.clk_div};
			// IRQ bit always reads 0
			`HK_REG_CTRL: tx_byte_o = {6'd0, cfg_q.sdo_override, cfg_q.ext_reset};
			`HK_REG_OUT_LO: tx_byte_o = cfg_q.io_out[7:0];
			`HK_REG_OUT_HI: tx_byte_o = cfg_q.io_out[`MPRJ_IO_PADS-1:8];
			`HK_REG_OEB_LO: tx_byte_o = cfg_q.io_oeb[7:0];
			`HK_REG_OEB_HI: tx_byte_o = cfg_q.io_oeb[`MPRJ_IO_PADS-1:8];
			`HK_REG_IN_LO: tx_byte_o = in_s2_q[7:0];
			`HK_REG_IN_HI: tx_byte_o = in_s2_q[`MPRJ_IO_PADS-1:8];
			default: tx_byte_o = 8'h00;
		endcase
	end

	// Load only after the address byte or a data byte of a read
	assign tx_load_o = rx_valid_i & ~rx_i.first & is_rd_q &
		(state_q == ST_ADDR || state_q == ST_DATA);

	// SDO driven only through the data phase of a read
	assign sdo_enb_o = ~(state_q == ST_DATA && is_rd_q);

endmodule

// File: logic/hk_spi_shift.sv
/*
 * Housekeeping SPI slave front end: pin synchroniser, SCK edge detect,
 * receive byte assembly and SDO transmit shifter (mode 0, MSB first)
 */
`timescale 1ns/1ps

module hk_spi_shift (
	input logic clock,
	input logic rst_i,
	input mgmt_pkg::spi_pins_t pins_i,
	output mgmt_pkg::spi_byte_t rx_o,
	output logic rx_valid_o,
	input logic [7:0] tx_byte_i,
	input logic tx_load_i,
	output logic sdo_o,
	output logic active_o
);

	// Two sync stages, third SCK stage is the edge history
	logic [2:0] sck_q;
	logic [1:0] csb_q;
	logic [1:0] sdi_q;
	logic sck_rise;
	logic sck_fall;
	logic csb_s;
	logic sdi_s;

	// Receive side
	logic [2:0] bit_cnt_q;
	logic first_q;
	logic [7:0] rx_shift_q;

	// Transmit side
	logic [7:0] tx_shift_q;
	logic [7:0] tx_pend_q;
	logic tx_pend_vld_q;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			sck_q <= 3'b000;
			// CSB idles high
			csb_q <= 2'b11;
			sdi_q <= 2'b00;
		end else begin
			sck_q <= {sck_q[1:0], pins_i.sck};
			csb_q <= {csb_q[0], pins_i.csb};
			sdi_q <= {sdi_q[0], pins_i.sdi};
		end
	end

	assign sck_rise = sck_q[1] & ~sck_q[2];
	assign sck_fall = ~sck_q[1] & sck_q[2];
	assign csb_s = csb_q[1];
	assign sdi_s = sdi_q[1];
	assign active_o = ~csb_s;

	// Bit counter and first-byte flag, both cleared while deselected
	always_ff @(posedge clock) begin
		if (rst_i) begin
			bit_cnt_q <= 3'd0;
			first_q <= 1'b1;
			rx_valid_o <= 1'b0;
		end else begin
			rx_valid_o <= 1'b0;
			if (csb_s) begin
				bit_cnt_q <= 3'd0;
				first_q <= 1'b1;
			end else if (sck_rise) begin
				bit_cnt_q <= bit_cnt_q + 3'd1;
				// Eighth bit completes the byte
				if (bit_cnt_q == 3'd7) begin
					rx_valid_o <= 1'b1;
					first_q <= 1'b0;
				end
			end
		end
	end

	// SDI sampled on rising SCK
	always_ff @(posedge clock) begin
		if (sck_rise) begin
			rx_shift_q <= {rx_shift_q[6:0], sdi_s};
		end
		if (sck_rise && !csb_s && bit_cnt_q == 3'd7) begin
			rx_o.data <= {rx_shift_q[6:0], sdi_s};
			rx_o.first <= first_q;
		end
	end

	// Byte from the register file waits here for the next falling edge
	always_ff @(posedge clock) begin
		if (tx_load_i) begin
			tx_pend_q <= tx_byte_i;
		end
	end

	always_ff @(posedge clock) begin
		if (rst_i) begin
			tx_pend_vld_q <= 1'b0;
			tx_shift_q <= 8'h00;
		end else if (csb_s) begin
			tx_pend_vld_q <= 1'b0;
			tx_shift_q <= 8'h00;
		end else begin
			if (tx_load_i) begin
				tx_pend_vld_q <= 1'b1;
			end else if (sck_fall) begin
				tx_pend_vld_q <= 1'b0;
			end
			if (sck_fall) begin
				tx_shift_q <= tx_pend_vld_q ? tx_pend_q : {tx_shift_q[6:0], 1'b0};
			end
		end
	end

	// Look ahead on a falling edge so SDO settles one cycle sooner
	assign sdo_o = sck_fall ? (tx_pend_vld_q ? tx_pend_q[7] : tx_shift_q[6]) : tx_shift_q[7];

endmodule

// File: logic/mgmt_clocking.sv
/*
 * Core reset synchroniser and core clock enable divider
 */
`timescale 1ns/1ps

module mgmt_clocking (
	input logic clock,
	input logic rst_i,
	input mgmt_pkg::hk_cfg_t cfg_i,
	output logic core_ce_o,
	output logic core_rst_o
);

	logic [1:0] rst_sync_q;
	logic [2:0] div_q;
	logic [2:0] cnt_q;

	// Held while either request is high, released 2 cycles later
	always_ff @(posedge clock) begin
		if (rst_i || cfg_i.ext_reset) begin
			rst_sync_q <= 2'b11;
		end else begin
			rst_sync_q <= {rst_sync_q[0], 1'b0};
		end
	end

	assign core_rst_o = rst_sync_q[1];

	// One enable pulse per clk_div+1 cycles
	always_ff @(posedge clock) begin
		if (rst_i) begin
			div_q <= 3'd0;
			cnt_q <= 3'd0;
			core_ce_o <= 1'b0;
		end else if (core_rst_o || cfg_i.clk_div != div_q) begin
			// Restart on core reset or a new divider value
			div_q <= cfg_i.clk_div;
			cnt_q <= 3'd0;
			core_ce_o <= 1'b0;
		end else if (cnt_q == div_q) begin
			cnt_q <= 3'd0;
			core_ce_o <= 1'b1;
		end else begin
			cnt_q <= cnt_q + 3'd1;
			core_ce_o <= 1'b0;
		end
	end

endmodule

// File: logic/mgmt_core.sv
/*
 * Management core top: housekeeping SPI, register file, clocking and I/O mux
 */
`timescale 1ns/1ps
`include "mgmt_config.svh"

module mgmt_core (
	input logic clock,
	input logic rst_i,
	// Housekeeping SPI pins
	input logic spi_sck_i,
	input logic spi_csb_i,
	input logic spi_sdi_i,
	output logic sdo_out_o,
	output logic sdo_outenb_o,
	// User I/O
	input logic [`MPRJ_IO_PADS-1:0] mgmt_in_data_i,
	output logic [`MPRJ_IO_PADS-1:0] mgmt_out_data_o,
	output logic [`MPRJ_IO_PADS-1:0] mgmt_oeb_o,
	// Metal programmed mask revision
	input logic [31:0] mask_rev_i,
	// Core clocking and interrupt
	output logic core_ce_o,
	output logic core_rst_o,
	output logic irq_o
);

	mgmt_pkg::spi_pins_t spi_pins;
	mgmt_pkg::spi_byte_t spi_rx;
	mgmt_pkg::hk_cfg_t hk_cfg;
	logic spi_rx_valid;
	logic spi_active;
	logic [7:0] spi_tx_byte;
	logic spi_tx_load;
	// Shifter output before override
	logic sdo_pre;

	assign spi_pins = '{sck: spi_sck_i, csb: spi_csb_i, sdi: spi_sdi_i};

	hk_spi_shift u_spi (
		.clock(clock),
		.rst_i(rst_i),
		.pins_i(spi_pins),
		.rx_o(spi_rx),
		.rx_valid_o(spi_rx_valid),
		.tx_byte_i(spi_tx_byte),
		.tx_load_i(spi_tx_load),
		.sdo_o(sdo_pre),
		.active_o(spi_active)
	);

	hk_regs u_regs (
		.clock(clock),
		.rst_i(rst_i),
		.rx_i(spi_rx),
		.rx_valid_i(spi_rx_valid),
		.active_i(spi_active),
		.tx_byte_o(spi_tx_byte),
		.tx_load_o(spi_tx_load),
		.sdo_enb_o(sdo_outenb_o),
		.mask_rev_i(mask_rev_i),
		.io_in_i(mgmt_in_data_i),
		.cfg_o(hk_cfg),
		.irq_o(irq_o)
	);

	mgmt_clocking u_clocking (
		.clock(clock),
		.rst_i(rst_i),
		.cfg_i(hk_cfg),
		.core_ce_o(core_ce_o),
		.core_rst_o(core_rst_o)
	);

	mgmt_io_mux u_io_mux (
		.clock(clock),
		.rst_i(rst_i),
		.cfg_i(hk_cfg),
		.sdo_pre_i(sdo_pre),
		.sdo_out_o(sdo_out_o),
		.mgmt_out_data_o(mgmt_out_data_o),
		.mgmt_oeb_o(mgmt_oeb_o)
	);

endmodule

// File: logic/mgmt_io_mux.sv
/*
 * User I/O output masking and SDO override, all outputs registered
 */
`timescale 1ns/1ps
`include "mgmt_config.svh"

module mgmt_io_mux (
	input logic clock,
	input logic rst_i,
	input mgmt_pkg::hk_cfg_t cfg_i,
	input logic sdo_pre_i,
	output logic sdo_out_o,
	output logic [`MPRJ_IO_PADS-1:0] mgmt_out_data_o,
	output logic [`MPRJ_IO_PADS-1:0] mgmt_oeb_o
);

	logic [`MPRJ_IO_PADS-1:0] out_d;

	// Two pins at each end are output only, the rest share in and out
	always_comb begin
		for (int i = 0; i < `MPRJ_IO_PADS; i++) begin
			if (i < 2 || i >= `MPRJ_IO_PADS - 2) begin
				out_d[i] = cfg_i.io_out[i];
			end else begin
				// Disabled shared pin drives 0
				out_d[i] = cfg_i.io_out[i] & ~cfg_i.io_oeb[i];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rst_i) begin
			sdo_out_o <= 1'b0;
			mgmt_out_data_o <= '0;
			mgmt_oeb_o <= `HK_OEB_RESET;
		end else begin
			// Host may take over SDO through io_out[1]
			sdo_out_o <= cfg_i.sdo_override ? cfg_i.io_out[1] : sdo_pre_i;
			mgmt_out_data_o <= out_d;
			mgmt_oeb_o <= cfg_i.io_oeb;
		end
	end

endmodule

// File: logic/mgmt_pkg.sv
/*
 * Shared structs: SPI pin bundle, received SPI byte, housekeeping configuration
 */
`include "mgmt_config.svh"

package mgmt_pkg;

	// Raw housekeeping SPI pins
	typedef struct packed {
		logic sck;
		logic csb;
		logic sdi;
	} spi_pins_t;

	// Completed byte from the SPI shifter
	typedef struct packed {
		// First byte since CSB fell, i.e. the command
		logic first;
		logic [7:0] data;
	} spi_byte_t;

	// Configuration driven by the housekeeping registers
	typedef struct packed {
		// Core clock enable divider
		logic [2:0] clk_div;
		// Core reset request from the host
		logic ext_reset;
		// SDO pin takes io_out[1] instead of the shifter
		logic sdo_override;
		logic [`MPRJ_IO_PADS-1:0] io_out;
		// Active high output disable per pin
		logic [`MPRJ_IO_PADS-1:0] io_oeb;
	} hk_cfg_t;

endpackage

// File: mgmt_core.f
+incdir+include
logic/mgmt_pkg.sv
logic/hk_spi_shift.sv
logic/hk_regs.sv
logic/mgmt_clocking.sv
logic/mgmt_io_mux.sv
logic/mgmt_core.sv
testbench/tb_mgmt_core.sv

// File: testbench/tb_mgmt_core.sv
/*
 * Management core testbench: SPI host, register model,
 * random write/read bursts, I/O, IRQ and clocking checks
 */
`timescale 1ns/1ps
`include "mgmt_config.svh"

module tb_mgmt_core;

	localparam int NUM_BURSTS = 200;
	// Run limit from transactions times bytes (framing included) times 64 cycles plus margin
	localparam int NUM_TXN = 2 * NUM_BURSTS + 20;
	localparam int TXN_BYTES = 11;
	localparam int LIMIT = NUM_TXN * TXN_BYTES * 64 + 5000;

	logic clock;
	logic rst_i;
	logic spi_sck;
	logic spi_csb;
	logic spi_sdi;
	logic sdo_out;
	logic sdo_outenb;
	logic [`MPRJ_IO_PADS-1:0] in_data;
	logic [`MPRJ_IO_PADS-1:0] out_data;
	logic [`MPRJ_IO_PADS-1:0] oeb;
	logic [31:0] mask_rev;
	logic core_ce;
	logic core_rst;
	logic irq;

	integer seed = 42728;
	logic [31:0] rnd;
	int cycle = 0;
	// Cycle of the latest rising SCK edge at the pin
	int rise_cyc;
	int irq_cyc;
	int irq_count = 0;
	int rst_fall_cyc;
	logic rst_prev = 1'b1;
	int fail_count = 0;

	// Register contents as the host should see them
	logic [7:0] model [0:15];
	logic [7:0] wr_data [0:15];
	logic [7:0] rd_data [0:15];

	mgmt_core UUT (
		.clock(clock),
		.rst_i(rst_i),
		.spi_sck_i(spi_sck),
		.spi_csb_i(spi_csb),
		.spi_sdi_i(spi_sdi),
		.sdo_out_o(sdo_out),
		.sdo_outenb_o(sdo_outenb),
		.mgmt_in_data_i(in_data),
		.mgmt_out_data_o(out_data),
		.mgmt_oeb_o(oeb),
		.mask_rev_i(mask_rev),
		.core_ce_o(core_ce),
		.core_rst_o(core_rst),
		.irq_o(irq)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= LIMIT) begin
			$display("Timeout: the run did not finish within %0d clock cycles", LIMIT);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

	// IRQ pulses and core reset release sampled mid-cycle
	always @(negedge clock) begin
		if (irq) begin
			irq_count <= irq_count + 1;
			irq_cyc <= cycle;
		end
		if (rst_prev && !core_rst) begin
			rst_fall_cyc <= cycle;
		end
		rst_prev <= core_rst;
	end

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			fail_count++;
			$display("FAIL at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	// Shared pins 2 to 13 drive 0 while disabled
	function automatic logic [15:0] masked_out(input logic [15:0] o, input logic [15:0] e);
		logic [15:0] r;
		for (int i = 0; i < `MPRJ_IO_PADS; i++) begin
			r[i] = (i >= 2 && i <= `MPRJ_IO_PADS - 3) ? (o[i] & ~e[i]) : o[i];
		end
		return r;
	endfunction

	function automatic logic [7:0] expect_byte(input logic [3:0] a);
		case (a)
			`HK_REG_MASK0: return mask_rev[31:24];
			`HK_REG_MASK1: return mask_rev[23:16];
			`HK_REG_MASK2: return mask_rev[15:8];
			`HK_REG_MASK3: return mask_rev[7:0];
			`HK_REG_IN_LO: return in_data[7:0];
			`HK_REG_IN_HI: return in_data[15:8];
			`HK_REG_CLKDIV, `HK_REG_CTRL, `HK_REG_OUT_LO, `HK_REG_OUT_HI,
			`HK_REG_OEB_LO, `HK_REG_OEB_HI: return model[a];
			default: return 8'h00;
		endcase
	endfunction

	// Read-only and unused addresses keep nothing
	function automatic void model_write(input logic [3:0] a, input logic [7:0] d);
		case (a)
			`HK_REG_CLKDIV: model[a] = {5'd0, d[2:0]};
			// IRQ bit is not stored
			`HK_REG_CTRL: model[a] = {6'd0, d[1:0]};
			`HK_REG_OUT_LO, `HK_REG_OUT_HI, `HK_REG_OEB_LO, `HK_REG_OEB_HI: model[a] = d;
			default: ;
		endcase
	endfunction

	// One SCK period of 4 cycles low and 4 high from a rising clock edge
	task automatic spi_bit(input logic b, output logic r, output logic enb);
		spi_sck <= 1'b0;
		spi_sdi <= b;
		repeat (3) @(posedge clock);
		// SDO just before the rising SCK edge
		@(negedge clock);
		r = sdo_out;
		enb = sdo_outenb;
		@(posedge clock);
		spi_sck <= 1'b1;
		@(negedge clock);
		rise_cyc = cycle;
		repeat (4) @(posedge clock);
	endtask

	task automatic spi_byte(input logic [7:0] b, input logic exp_enb, output logic [7:0] r);
		logic bit_r;
		logic bit_enb;
		for (int i = 7; i >= 0; i--) begin
			spi_bit(b[i], bit_r, bit_enb);
			r[i] = bit_r;
			check_equal(32'(bit_enb), 32'(exp_enb), "sdo_outenb_o within a byte");
		end
	endtask

	// Command and start address followed by len data bytes from wr_data or into rd_data
	task automatic spi_txn(input logic [7:0] cmd, input logic [3:0] addr, input int len);
		logic [7:0] r;
		logic rd;
		rd = (cmd == `HK_CMD_READ);
		@(posedge clock);
		spi_csb <= 1'b0;
		repeat (4) @(posedge clock);
		spi_byte(cmd, 1'b1, r);
		spi_byte({4'd0, addr}, 1'b1, r);
		for (int k = 0; k < len; k++) begin
			spi_byte(rd ? 8'h00 : wr_data[k], ~rd, r);
			rd_data[k] = r;
		end
		spi_sck <= 1'b0;
		repeat (4) @(posedge clock);
		spi_csb <= 1'b1;
		repeat (6) @(posedge clock);
	endtask

	// Settled outputs against the model
	task automatic check_pins();
		logic [15:0] io_out;
		logic [15:0] io_oeb;
		io_out = {model[`HK_REG_OUT_HI], model[`HK_REG_OUT_LO]};
		io_oeb = {model[`HK_REG_OEB_HI], model[`HK_REG_OEB_LO]};
		@(negedge clock);
		check_equal(32'(oeb), 32'(io_oeb), "mgmt_oeb_o");
		check_equal(32'(out_data), 32'(masked_out(io_out, io_oeb)), "mgmt_out_data_o");
		check_equal(32'(sdo_outenb), 32'd1, "idle sdo_outenb_o");
		// Override gives SDO io_out[1] and the idle shifter gives 0
		check_equal(32'(sdo_out), 32'(model[`HK_REG_CTRL][1] & io_out[1]), "idle sdo_out_o");
		check_equal(32'(core_rst), 32'(model[`HK_REG_CTRL][0]), "core_rst_o");
	endtask

	task automatic write_reg(input logic [3:0] a, input logic [7:0] d);
		wr_data[0] = d;
		model_write(a, d);
		spi_txn(`HK_CMD_WRITE, a, 1);
		check_pins();
	endtask

	task automatic check_ce_gaps(input int div);
		int last;
		@(negedge clock);
		while (!core_ce) @(negedge clock);
		last = cycle;
		repeat (4) begin
			@(negedge clock);
			while (!core_ce) @(negedge clock);
			check_equal(32'(cycle - last), 32'(div + 1), "core_ce_o pulse gap");
			last = cycle;
		end
	endtask

	initial begin : main
		logic [3:0] addr;
		logic [3:0] a;
		logic [7:0] d;
		int len;
		int exp_irq;
		spi_sck <= 1'b0;
		spi_csb <= 1'b1;
		spi_sdi <= 1'b0;
		in_data <= '0;
		rst_i <= 1'b1;
		rnd = $random(seed);
		mask_rev <= rnd;
		for (int i = 0; i < 16; i++) begin
			model[i] = 8'h00;
		end
		model[`HK_REG_OEB_LO] = 8'hff;
		model[`HK_REG_OEB_HI] = 8'hff;

		// State while still in reset
		repeat (15) @(posedge clock);
		@(negedge clock);
		check_equal(32'(oeb), 32'hffff, "mgmt_oeb_o in reset");
		check_equal(32'(out_data), 32'd0, "mgmt_out_data_o in reset");
		check_equal(32'({sdo_outenb, sdo_out, irq, core_ce, core_rst}), 32'b10001,
			"SPI, IRQ and core outputs in reset");
		@(posedge clock);
		rst_i <= 1'b0;

		// Mask revision read with the most significant byte first
		spi_txn(`HK_CMD_READ, `HK_REG_MASK0, 4);
		a = `HK_REG_MASK0;
		for (int k = 0; k < 4; k++) begin
			check_equal(32'(rd_data[k]), 32'(expect_byte(a)), "mask revision byte");
			a = a + 4'd1;
		end

		// Random write bursts each followed by a read back
		for (int t = 0; t < NUM_BURSTS; t++) begin
			rnd = $random(seed);
			addr = rnd[3:0];
			len = int'(rnd[6:4]) + 1;
			exp_irq = irq_count;
			a = addr;
			for (int k = 0; k < len; k++) begin
				rnd = $random(seed);
				d = rnd[7:0];
				// SDO override stays off so reads come from the shifter
				if (a == `HK_REG_CTRL) begin
					d[1] = 1'b0;
					exp_irq = exp_irq + int'(d[2]);
				end
				wr_data[k] = d;
				model_write(a, d);
				a = a + 4'd1;
			end
			spi_txn(`HK_CMD_WRITE, addr, len);
			check_pins();
			check_equal(32'(irq_count), 32'(exp_irq), "irq_o pulse count");
			rnd = $random(seed);
			@(posedge clock);
			in_data <= rnd[15:0];
			spi_txn(`HK_CMD_READ, addr, len);
			a = addr;
			for (int k = 0; k < len; k++) begin
				check_equal(32'(rd_data[k]), 32'(expect_byte(a)),
					$sformatf("read data at address %0d", a));
				a = a + 4'd1;
			end
		end

		// Unknown command is ignored for the whole transaction
		// Data differs from the stored bytes on every bit, always-driven pins included
		wr_data[0] = ~model[`HK_REG_OUT_LO];
		wr_data[1] = ~model[`HK_REG_OUT_HI];
		spi_txn(8'h20, `HK_REG_OUT_LO, 2);
		check_pins();

		// IRQ pulse and its timing
		write_reg(`HK_REG_CTRL, 8'h00);
		exp_irq = irq_count;
		write_reg(`HK_REG_CTRL, 8'h04);
		check_equal(32'(irq_count), 32'(exp_irq + 1), "irq_o cycles for one request");
		check_equal(32'(irq_cyc - rise_cyc), 32'd4, "irq_o delay from last SCK rise");

		// SDO override follows io_out[1]
		write_reg(`HK_REG_OUT_LO, 8'h02);
		write_reg(`HK_REG_CTRL, 8'h02);
		write_reg(`HK_REG_OUT_LO, 8'h00);
		write_reg(`HK_REG_OUT_LO, 8'h02);
		write_reg(`HK_REG_CTRL, 8'h00);

		// Core clock enable for every divider
		for (int div = 0; div < 8; div++) begin
			write_reg(`HK_REG_CLKDIV, 8'(div));
			check_ce_gaps(div);
		end

		// External reset hold and release
		write_reg(`HK_REG_CTRL, 8'h01);
		repeat (20) @(negedge clock);
		check_equal(32'(core_rst), 32'd1, "core_rst_o held by ext_reset");
		write_reg(`HK_REG_CTRL, 8'h00);
		check_equal(32'(rst_fall_cyc - rise_cyc), 32'd6, "core_rst_o release delay");

		if (fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
